// File: flist.f
exu_pkg.sv
exu_issue.sv
exu_int_alu.sv
exu_mul_seq.sv
exu_result_merge.sv
exu_top.sv
tb_exu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the execute unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_exu -o sim_exu

./obj_dir/sim_exu | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_exu.sv
`timescale 1ns/10ps

module tb_exu import exu_pkg::*; ();

    // drive edge to the edge where the checker sees res_valid
    localparam int alu_delay = 3;
    localparam int mul_delay = 35;
    localparam int mul_busy  = 33;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    exu_req_t        req;
    logic            flush;
    logic            busy;
    logic [xlen-1:0] res;
    logic            res_valid;
    logic [xlen-1:0] res_prev;

    integer          seed;
    int              cyc;
    int              errors;
    int              checks;
    logic [xlen-1:0] exp_data_q[$];
    int              exp_cyc_q[$];

    exu_top #(
        .mul_bits_per_cycle (2)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .flush     (flush),
        .busy      (busy),
        .res       (res),
        .res_valid (res_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference model, straight from the operand and operation rules
    function automatic logic [xlen-1:0] expected_result(input exu_req_t r);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [5:0]      sh;
        logic [31:0]     lo;
        logic            lt;
        a = (r.src_a == src_pc) ? r.pc : (r.word32 ? {32'h0, r.rs1[31:0]} : r.rs1);
        case (r.src_b)
            src_rs2: b = r.rs2;
            src_csr: b = r.csr;
            default: b = r.imm;
        endcase
        sh = b[5:0];
        // signed order decided by the sign bits when they differ
        lt = (a[63] != b[63]) ? a[63] : (a < b);
        lo = (a[31:0] >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        case (r.op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_ret_a: return a;
            op_ret_b: return b;
            op_xor:   return a ^ b;
            op_or:    return a | b;
            op_and:   return a & b;
            op_sll:   return a << sh;
            op_srl:   return a >> sh;
            op_sra:   return r.word32 ? {32'h0, lo} :
                          ((a >> sh) | (a[63] ? ~(64'hffff_ffff_ffff_ffff >> sh) : 64'h0));
            op_slt:   return {63'h0, lt};
            op_sltu:  return {63'h0, a < b};
            op_eq:    return {63'h0, a == b};
            op_ge:    return {63'h0, !lt};
            op_geu:   return {63'h0, !(a < b)};
            op_mul:   return a * b;
            default:  return 64'h0;
        endcase
    endfunction

    function automatic exu_req_t operand_req(input alu_op_e op, input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b, input logic w);
        exu_req_t r;
        r.op     = op;
        r.src_a  = src_rs1;
        r.src_b  = src_rs2;
        r.word32 = w;
        r.pc     = 64'h0000_0000_0000_4000;
        r.rs1    = a;
        r.rs2    = b;
        r.csr    = 64'h0000_0000_0000_0c5c;
        r.imm    = 64'hffff_ffff_ffff_f800;
        return r;
    endfunction

    task automatic random_req(input logic want_mul, output exu_req_t r);
        r.op     = want_mul ? op_mul : alu_op_e'(5'($unsigned($random(seed)) % 15));
        r.src_a  = src_a_e'(1'($random(seed)));
        r.src_b  = src_b_e'(2'($unsigned($random(seed)) % 3));
        r.word32 = 1'($random(seed));
        r.pc     = {$random(seed), $random(seed)};
        r.rs1    = {$random(seed), $random(seed)};
        r.rs2    = {$random(seed), $random(seed)};
        r.csr    = {$random(seed), $random(seed)};
        r.imm    = {$random(seed), $random(seed)};
    endtask

    // present one request, optionally expecting its result
    task automatic send(input exu_req_t r, input logic keep);
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= r;
        if (keep) begin
            exp_data_q.push_back(expected_result(r));
            exp_cyc_q.push_back(cyc + ((r.op == op_mul) ? mul_delay : alu_delay));
        end
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_busy_low(input int limit);
        bit done;
        done = 1'b0;
        for (int t = 0; t < limit && !done; t++) begin
            @(posedge clk);
            done = !busy;
        end
        if (!done) begin
            errors++;
            $display("ERROR at %0t: busy did not fall within %0d cycles", $time, limit);
        end
    endtask

    task automatic wait_drain(input int limit);
        int t;
        t = 0;
        while (exp_data_q.size() != 0 && t < limit) begin
            @(posedge clk);
            t++;
        end
        if (exp_data_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d results never arrived", $time, exp_data_q.size());
        end
    endtask

    // multiply and count the cycles busy is seen high
    task automatic run_mul(input exu_req_t r);
        int high;
        bit done;
        high = 0;
        done = 1'b0;
        send(r, 1'b1);
        idle();
        for (int t = 0; t < 100 && !done; t++) begin
            @(posedge clk);
            if (busy) begin
                high++;
            end else if (high > 0) begin
                done = 1'b1;
            end
        end
        checks++;
        if (!done) begin
            errors++;
            $display("ERROR at %0t: multiply never finished", $time);
        end else begin
            busy_len_a: assert (high == mul_busy) else begin
                errors++;
                $display("MISMATCH at %0t: busy cycles expected %0d actual %0d",
                         $time, mul_busy, high);
            end
        end
    endtask

    always @(posedge clk) begin : check_res
        logic [xlen-1:0] want;
        int              want_cyc;
        cyc      <= cyc + 1;
        res_prev <= res;
        if (arst_n && res_valid) begin
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: res_valid with no result outstanding", $time);
            end else begin
                want     = exp_data_q.pop_front();
                want_cyc = exp_cyc_q.pop_front();
                checks++;
                res_value_a: assert (res == want) else begin
                    errors++;
                    $display("MISMATCH at %0t: res expected %h actual %h", $time, want, res);
                end
                res_cycle_a: assert (cyc == want_cyc) else begin
                    errors++;
                    $display("MISMATCH at %0t: res_valid cycle expected %0d actual %0d",
                             $time, want_cyc, cyc);
                end
            end
        end
    end

    reset_state_a: assert property (@(posedge clk)
        !arst_n |-> (!busy && !res_valid && res == '0)) else begin
        errors++;
        $display("MISMATCH at %0t: busy/res_valid/res expected 0/0/0 actual %b/%b/%h",
                 $time, $sampled(busy), $sampled(res_valid), $sampled(res));
    end

    flush_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        (flush && busy && !in_valid) |=> !busy) else begin
        errors++;
        $display("MISMATCH at %0t: busy expected 0 actual 1", $time);
    end

    flush_squash_a: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (!res_valid && res == res_prev)) else begin
        errors++;
        $display("MISMATCH at %0t: res_valid expected 0 actual %b, res expected %h actual %h",
                 $time, $sampled(res_valid), $sampled(res_prev), $sampled(res));
    end

    initial begin : stimulus
        exu_req_t        r;
        logic [xlen-1:0] held;
        logic [xlen-1:0] min_v;
        logic [xlen-1:0] sh63;
        seed     = 32'h76a7;
        cyc      = 0;
        errors   = 0;
        checks   = 0;
        min_v    = 64'h8000_0000_0000_0000;
        sh63     = 64'hffff_ffff_ffff_ff7f;
        arst_n   = 1'b1;
        in_valid = 1'b0;
        flush    = 1'b0;
        req      = '0;
        #5 arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // isolated ALU ops, then one per cycle
        repeat (48) begin
            random_req(1'b0, r);
            send(r, 1'b1);
            idle();
        end
        repeat (32) begin
            random_req(1'b0, r);
            send(r, 1'b1);
        end
        idle();
        wait_drain(20);

        // compare and shift corners
        send(operand_req(op_slt, min_v, 64'd1, 1'b0), 1'b1);
        send(operand_req(op_sltu, min_v, 64'd1, 1'b0), 1'b1);
        send(operand_req(op_slt, 64'd1, min_v, 1'b0), 1'b1);
        send(operand_req(op_sra, min_v, sh63, 1'b0), 1'b1);
        send(operand_req(op_srl, min_v, sh63, 1'b0), 1'b1);
        send(operand_req(op_sll, 64'd1, sh63, 1'b0), 1'b1);
        send(operand_req(op_sra, 64'hdead_beef_8000_0000, 64'd4, 1'b1), 1'b1);
        send(operand_req(op_sra, 64'hffff_ffff_7fff_fff0, sh63, 1'b1), 1'b1);
        send(operand_req(op_ge, min_v, min_v, 1'b0), 1'b1);
        send(operand_req(op_geu, ~min_v, ~min_v, 1'b0), 1'b1);
        send(operand_req(op_ge, min_v, ~min_v, 1'b0), 1'b1);
        send(operand_req(op_sub, 64'd0, min_v, 1'b0), 1'b1);
        idle();
        wait_drain(20);

        repeat (5) begin
            random_req(1'b1, r);
            run_mul(r);
        end
        run_mul(operand_req(op_mul, min_v, 64'hffff_ffff_ffff_ffff, 1'b0));
        run_mul(operand_req(op_mul, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0));
        wait_drain(10);

        // requests during a multiply are dropped, the retry goes through
        random_req(1'b1, r);
        send(r, 1'b1);
        idle();
        random_req(1'b0, r);
        repeat (4) idle();
        repeat (10) send(r, 1'b0);
        idle();
        wait_busy_low(60);
        send(r, 1'b1);
        idle();
        wait_drain(20);

        // flush in the middle of a multiply
        random_req(1'b1, r);
        send(r, 1'b0);
        repeat (9) idle();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_busy_low(3);
        repeat (40) idle();

        // flush as an ALU result reaches the merge
        r = operand_req(op_add, 64'h1234, 64'h1, 1'b0);
        held = expected_result(r);
        send(r, 1'b1);
        idle();
        wait_drain(10);
        random_req(1'b0, r);
        send(r, 1'b0);
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (4) idle();
        checks++;
        held_a: assert (res == held) else begin
            errors++;
            $display("MISMATCH at %0t: res expected %h actual %h", $time, held, res);
        end
        wait_drain(10);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #2_000_000;
        $display("ERROR: simulation ran past its time limit");
        $display("checks: %0d  errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

endmodule

// File: exu_top.sv
`timescale 1ns/10ps

module exu_top import exu_pkg::*; #(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  exu_req_t         req,
    input  logic             flush,
    output logic             busy,
    output logic [xlen-1:0]  res,
    output logic             res_valid
);

    exu_opnd_t alu_in;
    logic      alu_in_valid;
    logic      mul_start;
    exu_opnd_t mul_opnd;
    exu_res_t  alu_res;
    exu_res_t  mul_res;

    exu_issue issue_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .req          (req),
        .busy         (busy),
        .alu_in       (alu_in),
        .alu_in_valid (alu_in_valid),
        .mul_start    (mul_start),
        .mul_opnd     (mul_opnd)
    );

    exu_int_alu alu_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .opnd       (alu_in),
        .opnd_valid (alu_in_valid),
        .alu_res    (alu_res)
    );

    exu_mul_seq #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) mul_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (mul_start),
        .flush   (flush),
        .opnd    (mul_opnd),
        .busy    (busy),
        .mul_res (mul_res)
    );

    exu_result_merge merge_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .alu_res   (alu_res),
        .mul_res   (mul_res),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

// File: exu_result_merge.sv
`timescale 1ns/10ps

module exu_result_merge import exu_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  exu_res_t         alu_res,
    input  exu_res_t         mul_res,
    output logic [xlen-1:0]  res,
    output logic             res_valid
);

    logic            any_valid;
    logic [xlen-1:0] sel_data;

    // issue stall keeps the two streams from arriving together
    assign any_valid = alu_res.valid | mul_res.valid;
    assign sel_data  = alu_res.valid ? alu_res.data : mul_res.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            // one-cycle strobe, squashed on flush
            res_valid <= any_valid & ~flush;
            // res holds until the next surviving result
            if (any_valid && !flush) begin
                res <= sel_data;
            end
        end
    end

endmodule

// File: exu_mul_seq.sv
`timescale 1ns/10ps

module exu_mul_seq import exu_pkg::*; #(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       flush,
    input  exu_opnd_t  opnd,
    output logic       busy,
    output exu_res_t   mul_res
);

    localparam int lat   = mul_latency(mul_bits_per_cycle);
    localparam int cnt_w = $clog2(lat);

    logic [cnt_w-1:0] cnt;
    logic             last;
    logic [xlen-1:0]  acc;
    logic [xlen-1:0]  mcand;
    logic [xlen-1:0]  mplier;
    logic [xlen-1:0]  partial;

    // final busy cycle presents the product
    assign last = (cnt == cnt_w'(lat - 1));

    // partial products of the next group of multiplier bits
    always_comb begin
        partial = '0;
        for (int k = 0; k < mul_bits_per_cycle; k++) begin
            if (mplier[k]) begin
                partial = partial + (mcand << k);
            end
        end
    end

    // control, a start in a flush cycle is younger than the flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (flush) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // data path, shift-add over the multiplier bits
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= opnd.a;
            mplier <= opnd.b;
        end else if (busy && !last) begin
            acc    <= acc + partial;
            mcand  <= mcand << mul_bits_per_cycle;
            mplier <= mplier >> mul_bits_per_cycle;
        end
    end

    // low 64 bits only, upper half is never kept
    assign mul_res.valid = busy & last;
    assign mul_res.data  = acc;

endmodule

// File: exu_int_alu.sv
`timescale 1ns/10ps

module exu_int_alu import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  exu_opnd_t  opnd,
    input  logic       opnd_valid,
    output exu_res_t   alu_res
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [5:0]      shamt;
    logic [31:0]     sra_word;
    logic [xlen-1:0] result;
    logic            res_valid_q;
    logic [xlen-1:0] res_data_q;

    assign a     = opnd.a;
    assign b     = opnd.b;
    assign shamt = b[5:0];

    // arithmetic shift of the low word only, sign taken from bit 31
    assign sra_word = $signed(a[31:0]) >>> shamt;

    always_comb begin
        case (opnd.op)
            op_add: begin
                result = a + b;
            end
            op_sub: begin
                result = a - b;
            end
            op_ret_a: begin
                result = a;
            end
            op_ret_b: begin
                result = b;
            end
            op_xor: begin
                result = a ^ b;
            end
            op_or: begin
                result = a | b;
            end
            op_and: begin
                result = a & b;
            end
            op_sll: begin
                result = a << shamt;
            end
            op_srl: begin
                result = a >> shamt;
            end
            op_sra: begin
                if (opnd.word32) begin
                    result = {32'b0, sra_word};
                end else begin
                    result = $signed(a) >>> shamt;
                end
            end
            // compares give 1 or 0
            op_slt: begin
                result = {63'b0, $signed(a) < $signed(b)};
            end
            op_sltu: begin
                result = {63'b0, a < b};
            end
            op_eq: begin
                result = {63'b0, a == b};
            end
            op_ge: begin
                result = {63'b0, $signed(a) >= $signed(b)};
            end
            op_geu: begin
                result = {63'b0, a >= b};
            end
            // op_mul never lands here
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= opnd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd_valid) begin
            res_data_q <= result;
        end
    end

    assign alu_res.valid = res_valid_q;
    assign alu_res.data  = res_data_q;

endmodule

// File: exu_issue.sv
`timescale 1ns/10ps

module exu_issue import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    input  exu_req_t   req,
    input  logic       busy,
    output exu_opnd_t  alu_in,
    output logic       alu_in_valid,
    output logic       mul_start,
    output exu_opnd_t  mul_opnd
);

    logic [xlen-1:0] opnd_a;
    logic [xlen-1:0] opnd_b;
    exu_opnd_t       opnd;
    logic            accept;
    logic            is_mul;

    // first operand with rs1 cut down to its low word in word mode
    always_comb begin
        if (req.src_a == src_pc) begin
            opnd_a = req.pc;
        end else if (req.word32) begin
            opnd_a = {32'b0, req.rs1[31:0]};
        end else begin
            opnd_a = req.rs1;
        end
    end

    // second operand
    always_comb begin
        case (req.src_b)
            src_rs2: opnd_b = req.rs2;
            src_csr: opnd_b = req.csr;
            default: opnd_b = req.imm;
        endcase
    end

    always_comb begin
        opnd.op     = req.op;
        opnd.a      = opnd_a;
        opnd.b      = opnd_b;
        opnd.word32 = req.word32;
    end

    // nothing is taken while a multiply is in flight
    assign accept = in_valid & ~busy;
    assign is_mul = (req.op == op_mul);

    // steer by op without an extra cycle
    assign mul_start    = accept & is_mul;
    assign alu_in_valid = accept & ~is_mul;

    // both parts see the same operands and the strobes pick the consumer
    assign alu_in   = opnd;
    assign mul_opnd = opnd;

endmodule

// File: exu_pkg.sv
package exu_pkg;

    // data path width
    localparam int xlen = 64;

    // operation codes seen by the execute unit
    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_ret_a = 5'd2,
        op_ret_b = 5'd3,
        op_xor   = 5'd4,
        op_or    = 5'd5,
        op_and   = 5'd6,
        op_sll   = 5'd7,
        op_srl   = 5'd8,
        op_sra   = 5'd9,
        op_slt   = 5'd10,
        op_sltu  = 5'd11,
        op_eq    = 5'd12,
        op_ge    = 5'd13,
        op_geu   = 5'd14,
        op_mul   = 5'd15
    } alu_op_e;

    // first operand source
    typedef enum logic {
        src_pc  = 1'b0,
        src_rs1 = 1'b1
    } src_a_e;

    // second operand source
    typedef enum logic [1:0] {
        src_imm = 2'd0,
        src_rs2 = 2'd1,
        src_csr = 2'd2
    } src_b_e;

    // one issued instruction as seen by the unit
    typedef struct packed {
        alu_op_e           op;
        src_a_e            src_a;
        src_b_e            src_b;
        logic              word32;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1;
        logic [xlen-1:0]   rs2;
        logic [xlen-1:0]   csr;
        logic [xlen-1:0]   imm;
    } exu_req_t;

    // resolved operands handed to a compute part
    typedef struct packed {
        alu_op_e           op;
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic              word32;
    } exu_opnd_t;

    // result of a compute part
    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   data;
    } exu_res_t;

    // busy cycles of the sequential multiplier
    // one cycle per group of multiplier bits, plus the result cycle
    function automatic int mul_latency(input int bits_per_cycle);
        int cycles;
        cycles = xlen / bits_per_cycle + 1;
        return cycles;
    endfunction

endpackage
